/* fft16_top.f */
design/fft_pkg.sv
design/sample_collector.sv
design/butterfly_unit.sv
design/fft_stage_engine.sv
design/result_serializer.sv
design/drain_detector.sv
design/fft16_top.sv
verification/fft16_tb.sv
+incdir+verification

/* run_sim.sh */
#!/bin/sh
# build and run the fft16 testbench, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    -f fft16_top.f --top-module fft16_tb --Mdir obj_dir -o fft16_sim \
    && ./obj_dir/fft16_sim | tee sim.log \
    || { echo "build or run failed"; exit 1; }

grep -q "^Simulation PASSED$" sim.log \
    && echo "run passed" \
    || { echo "run failed, see sim.log"; exit 1; }

/* verification/fft16_model.svh */
`ifndef FFT16_MODEL_SVH
`define FFT16_MODEL_SVH

localparam real MODEL_PI = 3.14159265358979;

function automatic logic [3:0] reverse_bits4(input logic [3:0] v);
    return {v[0], v[1], v[2], v[3]};
endfunction

// twiddle k of 16 in Q16, magnitude truncated toward zero
function automatic logic signed [31:0] twiddle(input int k, input bit imag_part);
    real ang;
    ang = 2.0 * MODEL_PI * k / 16.0;
    if (imag_part) begin
        return $rtoi(-$sin(ang) * 65536.0);
    end
    return $rtoi($cos(ang) * 65536.0);
endfunction

// bits 47:16 of a full product
function automatic logic signed [31:0] product_mid(input longint p);
    return p[47:16];
endfunction

// 16-point DIF FFT of a real frame, bins in natural order
function automatic void reference_fft(
    input  logic signed [15:0] samples [16],
    output logic signed [15:0] bins_re [16],
    output logic signed [15:0] bins_im [16]
);
    logic signed [31:0] re [16];
    logic signed [31:0] im [16];
    logic signed [31:0] d_re;
    logic signed [31:0] d_im;
    logic signed [31:0] w_re;
    logic signed [31:0] w_im;
    logic [3:0]         r;
    int                 span;
    int                 a;
    int                 b;
    for (int i = 0; i < 16; i++) begin
        re[i] = {{8{samples[i][15]}}, samples[i], 8'h00};
        im[i] = '0;
    end
    for (int s = 0; s < 4; s++) begin
        span = 8 >> s;
        for (int g = 0; g < 16; g += 2 * span) begin
            for (int j = 0; j < span; j++) begin
                a = g + j;
                b = a + span;
                w_re = twiddle(j << s, 1'b0);
                w_im = twiddle(j << s, 1'b1);
                d_re = re[a] - re[b];
                d_im = im[a] - im[b];
                re[a] = re[a] + re[b];
                im[a] = im[a] + im[b];
                // middle bits of each product, then the difference
                re[b] = product_mid(longint'(d_re) * longint'(w_re))
                      - product_mid(longint'(d_im) * longint'(w_im));
                im[b] = product_mid(longint'(d_re) * longint'(w_im))
                      + product_mid(longint'(d_im) * longint'(w_re));
            end
        end
    end
    for (int j = 0; j < 16; j++) begin
        r = reverse_bits4(4'(j));
        bins_re[j] = re[r][23:8];
        bins_im[j] = im[r][23:8];
    end
endfunction

`endif

/* verification/fft16_tb.sv */
`timescale 1ns/1ps

module fft16_tb;

    localparam int          CLK_PERIOD     = 20;
    localparam int          RESET_CYCLES   = 8;
    localparam logic [31:0] SEED           = 32'h35f2;
    localparam int          RANDOM_FRAMES  = 8;
    localparam int          TIMEOUT_CYCLES = (RANDOM_FRAMES + 2) * 40 + 200;
    localparam int          GAP_ONE_IN     = 4;
    localparam int          LATENCY        = 6;
    localparam logic signed [15:0] CONST_SAMPLE = 16'sd100;

    logic               clk;
    logic               rst;
    logic signed [15:0] fir_d;
    logic               fir_valid;
    logic               fft_valid;
    logic               done;
    logic signed [15:0] fft_d [16];

    logic [31:0]        rng_state;
    string              test_name;
    int                 test_errors;
    int                 total_errors;
    int                 tests_run;
    int                 tests_failed;

    // scoreboard and done model
    logic signed [15:0] cur_frame [16];
    logic signed [15:0] exp_re [16];
    logic signed [15:0] exp_im [16];
    logic signed [15:0] exp_q [$];
    int                 cur_count;
    int                 cyc;
    int                 last_accept_cyc;
    int                 frames_sent;
    int                 frames_seen;
    int                 burst_len;
    int                 done_pulses;
    logic               fir_prev;
    logic               fft_prev;
    logic               armed_model;
    logic               done_model;

    `include "fft16_model.svh"

    fft16_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .fir_d     (fir_d),
        .fir_valid (fir_valid),
        .fft_valid (fft_valid),
        .done      (done),
        .fft_d     (fft_d)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic report_mismatch(input string what, input int expected, input int actual);
        $display("** Error [%s] %s: expected %0d, actual %0d", test_name, what, expected, actual);
        test_errors++;
        total_errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("[%s] failure: %s", test_name, msg);
        test_errors++;
        total_errors++;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %-20s ok", test_name);
        end else begin
            tests_failed++;
            $display("test %-20s failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic drive_cycle(input logic valid, input logic signed [15:0] data);
        @(posedge clk);
        #1;
        fir_valid = valid;
        fir_d = data;
    endtask

    task automatic send_frame(input bit with_gaps);
        logic [31:0] r;
        for (int i = 0; i < 16; i++) begin
            if (with_gaps) begin
                r = next_random();
                while (r % GAP_ONE_IN == 0) begin
                    drive_cycle(1'b0, r[31:16]);
                    r = next_random();
                end
            end
            r = next_random();
            drive_cycle(1'b1, r[15:0]);
        end
    endtask

    // waits for done, then checks that every frame came out exactly once
    task automatic finish_stream(input int base);
        int waited;
        waited = 0;
        while (done_pulses == base && waited < 40) begin
            @(negedge clk);
            waited++;
        end
        repeat (4) @(negedge clk);
        if (done_pulses == base) begin
            report_failure("done never pulsed after the final frame");
        end else begin
            assert (done_pulses - base == 1)
                else report_mismatch("done pulses after last frame", 1, done_pulses - base);
        end
        assert (exp_q.size() == 0) else report_failure("a frame result never came out");
        assert (frames_seen == frames_sent)
            else report_mismatch("frames out", frames_sent, frames_seen);
    endtask

    task automatic check_constant_output();
        logic signed [15:0] e;
        int                 waited;
        waited = 0;
        while (fft_valid !== 1'b1 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (fft_valid !== 1'b1) begin
            report_failure("fft_valid never rose after the constant frame");
        end else begin
            for (int j = 0; j < 16; j++) begin
                e = (j == 0) ? 16'(16 * CONST_SAMPLE) : '0;
                assert (fft_d[j] === e)
                    else report_mismatch($sformatf("real bin %0d", j), int'(e), int'(fft_d[j]));
            end
            @(negedge clk);
            for (int j = 0; j < 16; j++) begin
                assert (fft_d[j] === 16'sd0)
                    else report_mismatch($sformatf("imag bin %0d", j), 0, int'(fft_d[j]));
            end
        end
    endtask

    //////////////////////////////
    // input monitor and models
    //////////////////////////////

    always @(posedge clk) begin : observe_inputs
        if (rst) begin
            cyc = 0;
            cur_count = 0;
            last_accept_cyc = 0;
            frames_sent = 0;
            fir_prev = 1'b0;
            fft_prev = 1'b0;
            armed_model = 1'b0;
            done_model = 1'b0;
            exp_q.delete();
        end else begin
            cyc++;
            // arm on the end of input, fire one edge after the end of a burst
            done_model = armed_model && fft_prev && !fft_valid;
            if (done_model) begin
                armed_model = 1'b0;
            end else if (fir_prev && !fir_valid) begin
                armed_model = 1'b1;
            end
            fir_prev = fir_valid;
            fft_prev = fft_valid;
            if (fir_valid) begin
                cur_frame[cur_count] = fir_d;
                cur_count++;
                if (cur_count == 16) begin
                    reference_fft(cur_frame, exp_re, exp_im);
                    for (int i = 0; i < 16; i++) begin
                        exp_q.push_back(exp_re[i]);
                    end
                    for (int i = 0; i < 16; i++) begin
                        exp_q.push_back(exp_im[i]);
                    end
                    cur_count = 0;
                    last_accept_cyc = cyc;
                    frames_sent++;
                end
            end
        end
    end

    always @(negedge clk) begin : check_outputs
        logic signed [15:0] e;
        if (rst) begin
            burst_len = 0;
            done_pulses = 0;
            frames_seen = 0;
        end else begin
            assert (done === done_model)
                else report_mismatch("done", int'(done_model), int'(done));
            if (done === 1'b1) begin
                done_pulses++;
            end
            if (fft_valid === 1'b1) begin
                burst_len++;
                if (burst_len == 1) begin
                    assert (cyc - last_accept_cyc == LATENCY)
                        else report_mismatch("fft_valid latency", LATENCY, cyc - last_accept_cyc);
                end
                if (exp_q.size() < 16) begin
                    report_failure("fft_valid high with no frame result pending");
                end else begin
                    for (int j = 0; j < 16; j++) begin
                        e = exp_q.pop_front();
                        assert (fft_d[j] === e)
                            else report_mismatch(
                                $sformatf("%s bin %0d", burst_len == 1 ? "real" : "imag", j),
                                int'(e), int'(fft_d[j]));
                    end
                end
                if (burst_len == 2) begin
                    frames_seen++;
                end
            end else if (burst_len != 0) begin
                assert (burst_len == 2)
                    else report_mismatch("fft_valid burst length", 2, burst_len);
                burst_len = 0;
            end
        end
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin : run_tests
        int base;
        rst = 1'b1;
        fir_valid = 1'b0;
        fir_d = '0;
        rng_state = SEED;
        test_errors = 0;
        total_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        test_name = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        begin_test("quiet_after_reset");
        repeat (30) begin
            @(negedge clk);
            assert (fft_valid === 1'b0) else report_mismatch("fft_valid", 0, int'(fft_valid));
            assert (done === 1'b0) else report_mismatch("done", 0, int'(done));
        end
        end_test();

        begin_test("constant_frame");
        for (int i = 0; i < 16; i++) begin
            drive_cycle(1'b1, CONST_SAMPLE);
        end
        drive_cycle(1'b0, '0);
        base = done_pulses;
        check_constant_output();
        finish_stream(base);
        end_test();

        begin_test("random_frame");
        send_frame(1'b0);
        drive_cycle(1'b0, '0);
        base = done_pulses;
        finish_stream(base);
        end_test();

        begin_test("random_gapped_frames");
        repeat (RANDOM_FRAMES) send_frame(1'b1);
        drive_cycle(1'b0, '0);
        base = done_pulses;
        finish_stream(base);
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog: run still going after %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* design/fft16_top.sv */
`timescale 1ns/1ps

module fft16_top import fft_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  sample_t fir_d,
    input  logic    fir_valid,
    output logic    fft_valid,
    output logic    done,
    output sample_t fft_d [N_POINTS]
);

    acc_t frame       [N_POINTS];
    acc_t result_real [N_POINTS];
    acc_t result_imag [N_POINTS];
    logic frame_ready;
    logic result_ready;

    sample_collector u_collector (
        .clk         (clk),
        .rst         (rst),
        .fir_d       (fir_d),
        .fir_valid   (fir_valid),
        .frame       (frame),
        .frame_ready (frame_ready)
    );

    fft_stage_engine u_engine (
        .clk          (clk),
        .rst          (rst),
        .frame        (frame),
        .frame_ready  (frame_ready),
        .result_real  (result_real),
        .result_imag  (result_imag),
        .result_ready (result_ready)
    );

    result_serializer u_serializer (
        .clk          (clk),
        .rst          (rst),
        .result_real  (result_real),
        .result_imag  (result_imag),
        .result_ready (result_ready),
        .fft_d        (fft_d),
        .fft_valid    (fft_valid)
    );

    drain_detector u_drain (
        .clk       (clk),
        .rst       (rst),
        .fir_valid (fir_valid),
        .fft_valid (fft_valid),
        .done      (done)
    );

endmodule

/* design/drain_detector.sv */
`timescale 1ns/1ps

module drain_detector (
    input  logic clk,
    input  logic rst,
    input  logic fir_valid,
    input  logic fft_valid,
    output logic done
);

    logic fir_q;
    logic fft_q;
    logic in_end;
    logic out_end;
    logic armed;

    // falling edges of both strobes
    assign in_end  = fir_q & ~fir_valid;
    assign out_end = fft_q & ~fft_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fir_q <= 1'b0;
            fft_q <= 1'b0;
            armed <= 1'b0;
            done  <= 1'b0;
        end else begin
            fir_q <= fir_valid;
            fft_q <= fft_valid;
            if (in_end) begin
                armed <= 1'b1;
            end
            // input stopped, last burst just left
            if (armed && out_end) begin
                armed <= 1'b0;
                done  <= 1'b1;
            end else begin
                done  <= 1'b0;
            end
        end
    end

endmodule

/* design/result_serializer.sv */
`timescale 1ns/1ps

module result_serializer import fft_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  acc_t    result_real [N_POINTS],
    input  acc_t    result_imag [N_POINTS],
    input  logic    result_ready,
    output sample_t fft_d [N_POINTS],
    output logic    fft_valid
);

    // high while the imaginary half is due
    logic phase_im;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase_im  <= 1'b0;
            fft_valid <= 1'b0;
        end else if (result_ready) begin
            phase_im  <= 1'b1;
            fft_valid <= 1'b1;
        end else if (phase_im) begin
            phase_im  <= 1'b0;
            fft_valid <= 1'b1;
        end else begin
            fft_valid <= 1'b0;
        end
    end

    // bins in natural order, middle 16 bits of each word
    always_ff @(posedge clk) begin
        for (int j = 0; j < N_POINTS; j++) begin
            if (result_ready) begin
                fft_d[j] <= result_real[bit_reverse(idx_t'(j))][FRAC_W+SAMPLE_W-1:FRAC_W];
            end else if (phase_im) begin
                fft_d[j] <= result_imag[bit_reverse(idx_t'(j))][FRAC_W+SAMPLE_W-1:FRAC_W];
            end
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // engine result must not come back while imag half is pending
    a_no_overrun: assert property (
        @(posedge clk) disable iff (rst) result_ready |-> !phase_im
    );

endmodule

/* design/fft_stage_engine.sv */
`timescale 1ns/1ps

module fft_stage_engine import fft_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  acc_t frame [N_POINTS],
    input  logic frame_ready,
    output acc_t result_real [N_POINTS],
    output acc_t result_imag [N_POINTS],
    output logic result_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DONE
    } state_t;

    state_t state;
    stage_t stage;
    logic   rd_from_a;

    // ping-pong banks
    acc_t bank_a_re [N_POINTS];
    acc_t bank_a_im [N_POINTS];
    acc_t bank_b_re [N_POINTS];
    acc_t bank_b_im [N_POINTS];

    acc_t rd_re [N_POINTS];
    acc_t rd_im [N_POINTS];

    idx_t    idx_a  [N_PAIRS];
    idx_t    idx_b  [N_PAIRS];
    tw_idx_t tw_sel [N_PAIRS];
    acc_t    x_re   [N_PAIRS];
    acc_t    x_im   [N_PAIRS];
    acc_t    y_re   [N_PAIRS];
    acc_t    y_im   [N_PAIRS];

    // even stages read A, odd stages read B
    assign rd_from_a = ~stage[0];

    always_comb begin
        for (int i = 0; i < N_POINTS; i++) begin
            rd_re[i] = rd_from_a ? bank_a_re[i] : bank_b_re[i];
            rd_im[i] = rd_from_a ? bank_a_im[i] : bank_b_im[i];
        end
    end

    //////////////////////////////
    // butterfly array
    //////////////////////////////

    for (genvar k = 0; k < N_PAIRS; k++) begin : g_bf
        assign idx_a[k]  = pair_a(stage, k);
        assign idx_b[k]  = pair_b(stage, k);
        assign tw_sel[k] = tw_index(stage, k);

        butterfly_unit u_bf (
            .a_re (rd_re[idx_a[k]]),
            .a_im (rd_im[idx_a[k]]),
            .b_re (rd_re[idx_b[k]]),
            .b_im (rd_im[idx_b[k]]),
            .w_re (TW_REAL[tw_sel[k]]),
            .w_im (TW_IMAG[tw_sel[k]]),
            .x_re (x_re[k]),
            .x_im (x_im[k]),
            .y_re (y_re[k]),
            .y_im (y_im[k])
        );
    end

    //////////////////////////////
    // state and bank update
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            stage <= '0;
            for (int i = 0; i < N_POINTS; i++) begin
                bank_a_re[i] <= '0;
                bank_a_im[i] <= '0;
                bank_b_re[i] <= '0;
                bank_b_im[i] <= '0;
            end
        end else begin
            case (state)
                ST_IDLE: begin
                    if (frame_ready) begin
                        // real input only
                        for (int i = 0; i < N_POINTS; i++) begin
                            bank_a_re[i] <= frame[i];
                            bank_a_im[i] <= '0;
                        end
                        stage <= '0;
                        state <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    for (int k = 0; k < N_PAIRS; k++) begin
                        if (rd_from_a) begin
                            bank_b_re[idx_a[k]] <= x_re[k];
                            bank_b_im[idx_a[k]] <= x_im[k];
                            bank_b_re[idx_b[k]] <= y_re[k];
                            bank_b_im[idx_b[k]] <= y_im[k];
                        end else begin
                            bank_a_re[idx_a[k]] <= x_re[k];
                            bank_a_im[idx_a[k]] <= x_im[k];
                            bank_a_re[idx_b[k]] <= y_re[k];
                            bank_a_im[idx_b[k]] <= y_im[k];
                        end
                    end
                    if (stage == stage_t'(N_STAGES - 1)) begin
                        state <= ST_DONE;
                    end else begin
                        stage <= stage + stage_t'(1);
                    end
                end
                ST_DONE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // last stage always lands in bank A
    assign result_real  = bank_a_re;
    assign result_imag  = bank_a_im;
    assign result_ready = (state == ST_DONE);

    //////////////////////////////
    // checks
    //////////////////////////////

    // collector frame rate must leave the engine time to finish
    a_no_overlap: assert property (
        @(posedge clk) disable iff (rst) frame_ready |-> state == ST_IDLE
    );

endmodule

/* design/butterfly_unit.sv */
`timescale 1ns/1ps

module butterfly_unit import fft_pkg::*; (
    input  acc_t a_re,
    input  acc_t a_im,
    input  acc_t b_re,
    input  acc_t b_im,
    input  acc_t w_re,
    input  acc_t w_im,
    output acc_t x_re,
    output acc_t x_im,
    output acc_t y_re,
    output acc_t y_im
);

    acc_t d_re;
    acc_t d_im;
    logic signed [2*ACC_W-1:0] p_rr;
    logic signed [2*ACC_W-1:0] p_ii;
    logic signed [2*ACC_W-1:0] p_ri;
    logic signed [2*ACC_W-1:0] p_ir;

    assign d_re = a_re - b_re;
    assign d_im = a_im - b_im;

    // middle bits of each product, then sum or difference
    assign p_rr = d_re * w_re;
    assign p_ii = d_im * w_im;
    assign p_ri = d_re * w_im;
    assign p_ir = d_im * w_re;

    assign x_re = a_re + b_re;
    assign x_im = a_im + b_im;
    assign y_re = p_rr[TW_FRAC+ACC_W-1:TW_FRAC] - p_ii[TW_FRAC+ACC_W-1:TW_FRAC];
    assign y_im = p_ri[TW_FRAC+ACC_W-1:TW_FRAC] + p_ir[TW_FRAC+ACC_W-1:TW_FRAC];

endmodule

/* design/sample_collector.sv */
`timescale 1ns/1ps

module sample_collector import fft_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  sample_t fir_d,
    input  logic    fir_valid,
    output acc_t    frame [N_POINTS],
    output logic    frame_ready
);

    idx_t cnt;

    // slot counter and frame strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt         <= '0;
            frame_ready <= 1'b0;
        end else if (fir_valid) begin
            cnt         <= cnt + idx_t'(1);
            frame_ready <= (cnt == idx_t'(N_POINTS - 1));
        end else begin
            frame_ready <= 1'b0;
        end
    end

    // sample sits in the middle of the working word
    always_ff @(posedge clk) begin
        if (fir_valid) begin
            frame[cnt] <= {{GUARD_W{fir_d[SAMPLE_W-1]}}, fir_d, {FRAC_W{1'b0}}};
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // one frame per 16 accepted samples, never back to back
    a_ready_single: assert property (
        @(posedge clk) disable iff (rst) frame_ready |=> !frame_ready
    );

endmodule

/* design/fft_pkg.sv */
package fft_pkg;

    localparam int N_POINTS = 16;
    localparam int N_PAIRS  = 8;
    localparam int N_STAGES = 4;
    localparam int SAMPLE_W = 16;
    localparam int ACC_W    = 32;
    localparam int GUARD_W  = 8;
    localparam int FRAC_W   = 8;
    localparam int TW_FRAC  = 16;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [ACC_W-1:0]    acc_t;
    typedef logic [3:0]                 idx_t;
    typedef logic [1:0]                 stage_t;
    typedef logic [2:0]                 tw_idx_t;

    // cos and -sin of 2*pi*k/16, Q16
    localparam acc_t TW_REAL [N_PAIRS] = '{
        32'sh00010000, 32'sh0000EC83, 32'sh0000B504, 32'sh000061F7,
        32'sh00000000, 32'shFFFF9E09, 32'shFFFF4AFC, 32'shFFFF137D
    };
    localparam acc_t TW_IMAG [N_PAIRS] = '{
        32'sh00000000, 32'shFFFF9E09, 32'shFFFF4AFC, 32'shFFFF137D,
        32'shFFFF0000, 32'shFFFF137D, 32'shFFFF4AFC, 32'shFFFF9E09
    };

    // upper point of butterfly k
    function automatic idx_t pair_a(stage_t stage, int k);
        int span;
        span = 8 >> stage;
        return idx_t'((2 * span) * (k / span) + (k % span));
    endfunction

    function automatic idx_t pair_b(stage_t stage, int k);
        return pair_a(stage, k) + idx_t'(8 >> stage);
    endfunction

    function automatic tw_idx_t tw_index(stage_t stage, int k);
        return tw_idx_t'((k % (8 >> stage)) << stage);
    endfunction

    function automatic idx_t bit_reverse(idx_t idx);
        return {idx[0], idx[1], idx[2], idx[3]};
    endfunction

endpackage
